// ==== src/img_filt_macros.svh ====
//######################################
// image size, colour widths and APB
// address width of the colour filter
//######################################
`ifndef IMG_FILT_MACROS_SVH
`define IMG_FILT_MACROS_SVH

// QQVGA / 2 frame
`define IMG_COLS 80
`define IMG_ROWS 60
`define IMG_PXLS 4800
`define NB_IMG_PXLS 13 // 4800 pixels need 13 bits

// bits per colour in the frame RAMs
`define NB_RED 4
`define NB_GREEN 4
`define NB_BLUE 4
`define NB_PXL (`NB_RED + `NB_GREEN + `NB_BLUE)

// byte address of one frame of 32-bit words, plus two region bits on top.
// 13-bit index gives 15 byte address bits, so the region lands in bits 16:15
// and the region bits always sit at NB_PADDR-1 and NB_PADDR-2
`define NB_PADDR (`NB_IMG_PXLS + 4)

`endif

// ==== src/img_filt_pkg.sv ====
//######################################
// pixel, address, filter mask, frame
// count and APB region types
//######################################
`default_nettype none
`include "img_filt_macros.svh"

package img_filt_pkg;

  // red in the top bits, then green, then blue
  typedef logic [`NB_PXL-1:0] pxl_t;

  typedef logic [`NB_IMG_PXLS-1:0] pxl_addr_t; // pixel index in a frame

  // bit 2 red, bit 1 green, bit 0 blue
  // zero = no filter
  typedef logic [2:0] rgb_filter_t;

  typedef logic [15:0] frame_cnt_t; // completed frames, wraps

  // two top address bits
  typedef enum logic [1:0] {
    ORIG = 2'b00, // original frame, read/write
    PROC = 2'b01, // processed frame, read only
    STAT = 2'b10, // filter mask and frame count
    NONE = 2'b11  // unmapped
  } apb_region_t;

endpackage

`default_nettype wire

// ==== src/frame_mem_if.sv ====
//######################################
// one port of a frame RAM
//######################################
`default_nettype none

interface frame_mem_if;

  img_filt_pkg::pxl_addr_t addr;  // pixel index
  img_filt_pkg::pxl_t      wdata;
  logic                    we;    // write on this edge
  img_filt_pkg::pxl_t      rdata; // one clock after addr

  // side that owns the address
  modport ctrl (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  // the RAM itself
  modport mem (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

`default_nettype wire

// ==== src/frame_ram.sv ====
//######################################
// frame RAM, two read/write ports
// registered reads
//######################################
`default_nettype none
`include "img_filt_macros.svh"

module frame_ram (
  input  wire       rst, // clock
  frame_mem_if.mem  a,
  frame_mem_if.mem  b
);

  // one pixel per entry, no reset on the contents
  img_filt_pkg::pxl_t mem [`IMG_PXLS];

  // both ports write in the same block
  // so a same-address collision resolves to port b
  always_ff @(posedge rst) begin
    if (a.we) begin
      mem[a.addr] <= a.wdata;
    end
    if (b.we) begin
      mem[b.addr] <= b.wdata; // b last, b wins
    end
  end

  // read-before-write on both ports
  always_ff @(posedge rst) begin
    a.rdata <= mem[a.addr];
    b.rdata <= mem[b.addr];
  end

endmodule

`default_nettype wire

// ==== src/apb_frame_port.sv ====
//######################################
// APB slave onto the two frame RAMs
// plus filter and frame count status
//######################################
`default_nettype none
`include "img_filt_macros.svh"

module apb_frame_port (
  input  wire                             rst,     // clock
  input  wire                             clk,     // async reset, active high
  input  wire                             psel,
  input  wire                             penable,
  input  wire                             pwrite,
  input  wire [`NB_PADDR-1:0]             paddr,
  input  wire [31:0]                      pwdata,
  output logic [31:0]                     prdata,
  output logic                            pready,
  output logic                            pslverr,
  frame_mem_if.ctrl                       orig,    // port a of original RAM
  frame_mem_if.ctrl                       proc,    // port b of processed RAM
  input  wire img_filt_pkg::rgb_filter_t  rgb_filter,
  input  wire img_filt_pkg::frame_cnt_t   frame_cnt
);

  // WAIT is the second access cycle of a frame read
  // DONE covers the cycle after pready, bus is idle or in setup
  typedef enum logic [1:0] {IDLE, WAIT, DONE} apb_st_t;

  apb_st_t                   state;
  apb_st_t                   state_nxt;
  img_filt_pkg::apb_region_t region;
  img_filt_pkg::pxl_addr_t   pxl_idx;
  logic                      access;    // access phase of a transfer
  logic                      frame_rgn;
  logic                      idx_err;
  logic                      acc_err;
  logic                      frame_rd;  // needs the wait state

  assign access  = psel & penable;
  assign region  = img_filt_pkg::apb_region_t'(paddr[`NB_PADDR-1 -: 2]);
  assign pxl_idx = paddr[`NB_IMG_PXLS+1:2]; // word index

  assign frame_rgn = (region == img_filt_pkg::ORIG) | (region == img_filt_pkg::PROC);
  assign idx_err   = frame_rgn & (pxl_idx >= `IMG_PXLS); // past the last pixel

  // only the original frame takes writes
  assign acc_err = idx_err | (region == img_filt_pkg::NONE) |
                   (pwrite & (region != img_filt_pkg::ORIG));

  assign frame_rd = frame_rgn & ~pwrite & ~acc_err;

  // RAM ports, address held at 0 outside valid accesses
  assign orig.addr  = (access & (region == img_filt_pkg::ORIG) & ~idx_err) ? pxl_idx : '0;
  assign orig.wdata = pwdata[`NB_PXL-1:0]; // upper bus bits dropped
  assign orig.we    = (state == IDLE) & access & pwrite & ~acc_err;

  assign proc.addr  = (access & (region == img_filt_pkg::PROC) & ~idx_err) ? pxl_idx : '0;
  assign proc.wdata = '0; // read only from the host side
  assign proc.we    = 1'b0;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (access) begin
          state_nxt = frame_rd ? WAIT : DONE; // RAM data next clock
        end
      end
      WAIT:    state_nxt = DONE;
      default: state_nxt = IDLE;
    endcase
  end

  // writes, status and errors finish in the first access cycle
  assign pready  = access & (((state == IDLE) & ~frame_rd) | (state == WAIT));
  assign pslverr = access & (state == IDLE) & acc_err;

  // read mux, zero unless a good read completes
  always_comb begin
    prdata = '0;
    if (pready & ~pwrite & ~acc_err) begin
      case (region)
        img_filt_pkg::ORIG: prdata = 32'(orig.rdata);
        img_filt_pkg::PROC: prdata = 32'(proc.rdata);
        img_filt_pkg::STAT: prdata = paddr[2] ? 32'(frame_cnt) : 32'(rgb_filter); // offset 4 / 0
        default:            prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/color_proc.sv ====
//######################################
// button sync, filter sequencer, scan
// pipeline and colour mask
//######################################
`default_nettype none
`include "img_filt_macros.svh"

module color_proc (
  input  wire                        rst,        // clock
  input  wire                        clk,        // async reset, active high
  input  wire                        proc_ctrl,  // push button, asynchronous
  frame_mem_if.ctrl                  orig,       // read only
  frame_mem_if.ctrl                  proc,       // write only
  output img_filt_pkg::rgb_filter_t  rgb_filter,
  output img_filt_pkg::frame_cnt_t   frame_cnt
);

  // top bit of each colour inside a pixel
  localparam int MSB_RED   = `NB_PXL - 1;
  localparam int MSB_GREEN = `NB_GREEN + `NB_BLUE - 1;
  localparam int MSB_BLUE  = `NB_BLUE - 1;

  logic                      btn_s1;
  logic                      btn_s2;
  logic                      btn_s3;     // delayed copy for the edge
  logic                      btn_rise;
  img_filt_pkg::pxl_addr_t   rd_addr;    // issue stage
  img_filt_pkg::pxl_addr_t   s1_addr;    // RAM data stage
  img_filt_pkg::pxl_addr_t   s2_addr;    // write stage
  img_filt_pkg::rgb_filter_t frame_mask;
  img_filt_pkg::rgb_filter_t issue_mask;
  img_filt_pkg::rgb_filter_t s1_mask;
  logic                      s1_vld;
  logic                      s2_we;
  logic                      last_pxl;
  logic [2:0]                msb_set;    // same order as the mask
  logic                      pass;
  img_filt_pkg::pxl_t        filt_pxl;
  img_filt_pkg::pxl_t        s2_pxl;

  // two sync flops, third one for the rising edge
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      btn_s1 <= 1'b0;
      btn_s2 <= 1'b0;
      btn_s3 <= 1'b0;
    end else begin
      btn_s1 <= proc_ctrl;
      btn_s2 <= btn_s1;
      btn_s3 <= btn_s2;
    end
  end

  assign btn_rise = btn_s2 & ~btn_s3;

  // none, R, G, B, RG, RB, GB, RGB and round again
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rgb_filter <= 3'b000;
    end else if (btn_rise) begin
      case (rgb_filter)
        3'b000:  rgb_filter <= 3'b100;
        3'b100:  rgb_filter <= 3'b010;
        3'b010:  rgb_filter <= 3'b001;
        3'b001:  rgb_filter <= 3'b110;
        3'b110:  rgb_filter <= 3'b101;
        3'b101:  rgb_filter <= 3'b011;
        3'b011:  rgb_filter <= 3'b111;
        default: rgb_filter <= 3'b000; // after RGB
      endcase
    end
  end

  assign last_pxl = (rd_addr == `IMG_PXLS - 1);

  // new mask only at the start of a frame
  assign issue_mask = (rd_addr == '0) ? rgb_filter : frame_mask;

  // scan never stalls
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rd_addr   <= '0;
      s1_vld    <= 1'b0;
      s2_we     <= 1'b0;
      frame_cnt <= '0;
    end else begin
      rd_addr <= last_pxl ? '0 : rd_addr + 1'b1;
      s1_vld  <= 1'b1;
      s2_we   <= s1_vld; // stays high after the first write
      if (s2_we && (s2_addr == `IMG_PXLS - 1)) begin
        frame_cnt <= frame_cnt + 1'b1; // last pixel written
      end
    end
  end

  // address and mask travel with the pixel
  always_ff @(posedge rst) begin
    frame_mask <= issue_mask;
    s1_addr    <= rd_addr;
    s1_mask    <= issue_mask;
    s2_addr    <= s1_addr;
    s2_pxl     <= filt_pxl;
  end

  assign msb_set = {orig.rdata[MSB_RED], orig.rdata[MSB_GREEN], orig.rdata[MSB_BLUE]};

  // unselected colours count as set
  assign pass     = &(msb_set | ~s1_mask);
  assign filt_pxl = pass ? orig.rdata : '0; // black otherwise

  assign orig.addr  = rd_addr;
  assign orig.wdata = '0;
  assign orig.we    = 1'b0;

  assign proc.addr  = s2_addr;
  assign proc.wdata = s2_pxl;
  assign proc.we    = s2_we;

endmodule

`default_nettype wire

// ==== src/color_filt_top.sv ====
//######################################
// colour filter top level
// APB port, two frame RAMs and scan
//######################################
`default_nettype none
`include "img_filt_macros.svh"

module color_filt_top (
  input  wire                  rst,       // clock
  input  wire                  clk,       // async reset, active high
  input  wire                  proc_ctrl, // filter step button
  input  wire                  psel,
  input  wire                  penable,
  input  wire                  pwrite,
  input  wire [`NB_PADDR-1:0]  paddr,
  input  wire [31:0]           pwdata,
  output wire [31:0]           prdata,
  output wire                  pready,
  output wire                  pslverr
);

  img_filt_pkg::rgb_filter_t rgb_filter;
  img_filt_pkg::frame_cnt_t  frame_cnt;

  frame_mem_if orig_host ();
  frame_mem_if orig_scan ();
  frame_mem_if proc_scan ();
  frame_mem_if proc_host ();

  // host writes, scan reads
  frame_ram i_orig_ram (
    .rst (rst),
    .a   (orig_host),
    .b   (orig_scan)
  );

  // scan writes, host reads
  frame_ram i_proc_ram (
    .rst (rst),
    .a   (proc_scan),
    .b   (proc_host)
  );

  apb_frame_port i_apb_frame_port (
    .rst        (rst),
    .clk        (clk),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .orig       (orig_host),
    .proc       (proc_host),
    .rgb_filter (rgb_filter),
    .frame_cnt  (frame_cnt)
  );

  color_proc i_color_proc (
    .rst        (rst),
    .clk        (clk),
    .proc_ctrl  (proc_ctrl),
    .orig       (orig_scan),
    .proc       (proc_scan),
    .rgb_filter (rgb_filter),
    .frame_cnt  (frame_cnt)
  );

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
//########################################
// testbench clock and power-on reset
//########################################
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 3
) (
  output logic rst, // clock
  output logic clk  // reset, active high
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    rst = 1'b0;
    forever #(PERIOD_NS / 2) rst = ~rst;
  end

  // reset high from time 0, dropped on a rising edge
  initial begin
    clk = 1'b1;
    repeat (RST_CYCLES) @(posedge rst);
    clk <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== dv/color_filt_tb.sv ====
//########################################
// colour filter testbench
// APB tasks, frame model, filter model
// and the scenario checks
//########################################
`default_nettype none
`include "img_filt_macros.svh"

module color_filt_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED      = 32'h30be_d861;
  localparam int APB_TIMEOUT        = 8;   // access cycles before giving up
  localparam int POLL_GAP           = 100; // idle clocks between count polls
  localparam int FRAME_POLLS        = 100; // polls allowed per frame
  localparam int FRAME_CNT_OFFS     = 4;
  localparam int FILTER_OFFS        = 0;

  logic                 rst; // clock
  logic                 clk; // reset
  logic                 proc_ctrl;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [`NB_PADDR-1:0] paddr;
  logic [31:0]          pwdata;
  logic [31:0]          prdata;
  logic                 pready;
  logic                 pslverr;

  logic [`NB_PXL-1:0] orig_model [`IMG_PXLS]; // what the host wrote
  int                 errors = 0;

  clk_gen #(.PERIOD_NS(40), .RST_CYCLES(3)) i_clk_gen (
    .rst (rst),
    .clk (clk)
  );

  color_filt_top i_color_filt_top (
    .rst       (rst),
    .clk       (clk),
    .proc_ctrl (proc_ctrl),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge rst);
  endtask

  // masks in button order none R G B RG RB GB RGB
  function automatic logic [2:0] mask_at(input int step);
    case (step % 8)
      0:       return 3'b000;
      1:       return 3'b100; // red
      2:       return 3'b010; // green
      3:       return 3'b001; // blue
      4:       return 3'b110;
      5:       return 3'b101;
      6:       return 3'b011;
      default: return 3'b111;
    endcase
  endfunction

  // pixel survives only if every picked colour has its top bit set
  function automatic logic [`NB_PXL-1:0] filtered(input logic [`NB_PXL-1:0] p,
                                                   input logic [2:0] m);
    logic red_ok;
    logic green_ok;
    logic blue_ok;
    red_ok   = !m[2] || p[`NB_PXL-1];
    green_ok = !m[1] || p[`NB_GREEN+`NB_BLUE-1];
    blue_ok  = !m[0] || p[`NB_BLUE-1];
    return (red_ok && green_ok && blue_ok) ? p : '0;
  endfunction

  // region on top, word index below, byte offset 0
  function automatic logic [`NB_PADDR-1:0] frame_addr(input logic [1:0] rgn,
                                                      input int unsigned idx);
    logic [`NB_PADDR-3:0] offs;
    offs = (`NB_PADDR-2)'(idx * 4);
    return {rgn, offs};
  endfunction

  function automatic logic [`NB_PADDR-1:0] stat_addr(input int unsigned offs);
    return {2'b10, (`NB_PADDR-2)'(offs)};
  endfunction

  task automatic apb_xfer(
    input  logic                 wr,
    input  logic [`NB_PADDR-1:0] addr,
    input  logic [31:0]          wdata,
    output logic [31:0]          rdata,
    output logic                 err
  );
    int   waits;
    logic frame_rd;
    waits = 0;
    // one wait state only for an in-range frame read
    frame_rd = !wr && !addr[`NB_PADDR-1] && (addr[`NB_IMG_PXLS+1:2] < `IMG_PXLS);
    @(posedge rst);
    psel    <= 1'b1; // setup
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge rst);
    penable <= 1'b1; // access
    @(negedge rst);
    while (!pready) begin
      waits++;
      if (waits > APB_TIMEOUT) begin
        $display("APB transfer to address 0x%0h never completed", addr);
        stop_on_failure();
      end else begin
        @(negedge rst);
      end
    end
    check_val("pready wait states", 32'(frame_rd), waits);
    rdata = prdata;
    err   = pslverr;
    @(posedge rst);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic host_write(input int unsigned idx, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, frame_addr(2'b00, idx), data, rd, err);
    check_val("pslverr", 0, err);
  endtask

  task automatic host_read(input logic [1:0] rgn, input int unsigned idx,
                           output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, frame_addr(rgn, idx), 32'h0, data, err);
    check_val("pslverr", 0, err);
  endtask

  task automatic read_stat(input int unsigned offs, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, stat_addr(offs), 32'h0, data, err);
    check_val("pslverr", 0, err);
  endtask

  // baseline taken a few clocks after the last change
  task automatic wait_frames(input int n);
    logic [31:0] start;
    logic [31:0] now;
    int          polls;
    idle(4);
    read_stat(FRAME_CNT_OFFS, start);
    now   = start;
    polls = 0;
    while (16'(now - start) < 16'(n)) begin
      polls++;
      if (polls > n * FRAME_POLLS) begin
        $display("frame count stuck at 0x%0h while waiting for %0d frames", now, n);
        stop_on_failure();
      end else begin
        idle(POLL_GAP);
        read_stat(FRAME_CNT_OFFS, now);
      end
    end
  endtask

  task automatic check_orig_frame();
    logic [31:0] rd;
    for (int i = 0; i < `IMG_PXLS; i++) begin
      host_read(2'b00, i, rd);
      check_val($sformatf("prdata (original pixel %0d)", i), 32'(orig_model[i]), rd);
    end
  endtask

  task automatic check_proc_frame(input logic [2:0] m);
    logic [31:0] rd;
    for (int i = 0; i < `IMG_PXLS; i++) begin
      host_read(2'b01, i, rd);
      check_val($sformatf("prdata (processed pixel %0d)", i),
                32'(filtered(orig_model[i], m)), rd);
    end
  endtask

  task automatic press_button();
    @(posedge rst);
    proc_ctrl <= 1'b1;
    idle(2);
    proc_ctrl <= 1'b0;
    idle(4); // mask register moves 3 clocks after the edge
  endtask

  // every access here must end in pslverr
  task automatic error_accesses();
    logic [31:0] rd;
    logic        err;
    int unsigned idx;
    repeat (8) begin
      idx = $urandom_range(0, `IMG_PXLS - 1);
      apb_xfer(1'b1, frame_addr(2'b01, idx), $urandom, rd, err);
      check_val("pslverr (write to processed frame)", 1, err);
      apb_xfer(1'b1, stat_addr(FILTER_OFFS), $urandom, rd, err);
      check_val("pslverr (write to filter register)", 1, err);
      apb_xfer(1'b1, stat_addr(FRAME_CNT_OFFS), $urandom, rd, err);
      check_val("pslverr (write to frame count)", 1, err);
      idx = $urandom_range(`IMG_PXLS, (1 << `NB_IMG_PXLS) - 1); // past the frame
      apb_xfer(1'b1, frame_addr(2'b00, idx), $urandom, rd, err);
      check_val("pslverr (original write out of range)", 1, err);
      apb_xfer(1'b0, frame_addr(2'b00, idx), 32'h0, rd, err);
      check_val("pslverr (original read out of range)", 1, err);
      apb_xfer(1'b0, frame_addr(2'b01, idx), 32'h0, rd, err);
      check_val("pslverr (processed read out of range)", 1, err);
      apb_xfer(1'b0, frame_addr(2'b11, idx), 32'h0, rd, err);
      check_val("pslverr (read of unmapped region)", 1, err);
      apb_xfer(1'b1, frame_addr(2'b11, idx), $urandom, rd, err);
      check_val("pslverr (write to unmapped region)", 1, err);
    end
    // original frame untouched
    check_orig_frame();
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    int          step;
    int          pulses;
    int          waits;
    int unsigned idx;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    proc_ctrl = 1'b0;
    void'($urandom(SEED));
    step  = 0;
    waits = 0;

    while (clk !== 1'b0) begin
      waits++;
      if (waits > 10) begin
        $display("reset never released");
        stop_on_failure();
      end else begin
        @(posedge rst);
      end
    end

    // quiet bus and cleared status out of reset
    @(negedge rst);
    check_val("pready", 0, pready);
    check_val("pslverr", 0, pslverr);
    read_stat(FILTER_OFFS, rd);
    check_val("rgb_filter", 0, rd);
    read_stat(FRAME_CNT_OFFS, rd);
    check_val("frame_cnt", 0, rd);

    // full random frame with random upper bus bits
    for (int i = 0; i < `IMG_PXLS; i++) begin
      data          = $urandom;
      orig_model[i] = data[`NB_PXL-1:0];
      host_write(i, data);
    end
    check_orig_frame();

    // no filter gives a straight copy
    wait_frames(2);
    check_proc_frame(mask_at(step));

    repeat (3) begin
      pulses = $urandom_range(1, 8);
      repeat (pulses) begin
        press_button();
        step++;
        read_stat(FILTER_OFFS, rd);
        check_val("rgb_filter", 32'(mask_at(step)), rd);
      end
      wait_frames(2);
      check_proc_frame(mask_at(step));
    end

    error_accesses();

    // rewrite while the scan keeps running
    repeat (200) begin
      idx             = $urandom_range(0, `IMG_PXLS - 1);
      data            = $urandom;
      orig_model[idx] = data[`NB_PXL-1:0];
      host_write(idx, data);
    end
    wait_frames(2);
    check_proc_frame(mask_at(step));
    check_orig_frame();

    if (errors == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/img_filt_pkg.sv
src/frame_mem_if.sv
src/frame_ram.sv
src/apb_frame_port.sv
src/color_proc.sv
src/color_filt_top.sv
dv/clk_gen.sv
dv/color_filt_tb.sv

// ==== Bender.yml ====
package:
  name: color_filt

sources:
  - include_dirs:
      - src
    files:
      - src/img_filt_pkg.sv
      - src/frame_mem_if.sv
      - src/frame_ram.sv
      - src/apb_frame_port.sv
      - src/color_proc.sv
      - src/color_filt_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/clk_gen.sv
      - dv/color_filt_tb.sv
